// File: src/fpPkg.sv
// Single-precision widths, special constants and the float word type shared by the adder stages
package fpPkg;

    localparam int WORD_W = 32;                  // Whole IEEE-754 single word
    localparam int EXP_W  = 8;                   // Biased exponent field
    localparam int MAN_W  = 23;                  // Stored fraction without the hidden one
    localparam int EXT_W  = MAN_W + 1;           // Fraction with the hidden one restored

    // Sum between stages holds carry, magnitude, guard, round and sticky
    localparam int SUM_W  = EXT_W + 4;

    // All-ones exponent marks infinity or NaN
    localparam logic [EXP_W-1:0] EXP_MAX = '1;

    localparam logic [WORD_W-1:0] QNAN = 32'h7FC0_0000;    // Canonical quiet NaN

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exponent;
        logic [MAN_W-1:0] fraction;
    } fpFields;

    // One word read either raw or as its decoded fields
    typedef union packed {
        logic [WORD_W-1:0] bits;
        fpFields           f;
    } fpWord;

endpackage

// File: src/fpBusIf.sv
// Interfaces that carry one addition from alignment to the adder and on to normalization
`timescale 1ns/100ps

// Stage one results, every signal comes from a register
interface alignBus;
    logic                    valid;
    logic                    signA;
    logic                    signB;
    logic [fpPkg::EXP_W-1:0] exponentOut;         // Larger of the two exponents
    logic [fpPkg::EXT_W-1:0] alignedMantissaA;
    logic [fpPkg::EXT_W-1:0] alignedMantissaB;
    logic                    guardBit;            // Bits below the shifted operand
    logic                    roundBit;
    logic                    stickyBit;
    logic                    special;             // specialWord is the final answer
    fpPkg::fpWord            specialWord;

    modport source (output valid, signA, signB, exponentOut, alignedMantissaA,
                    alignedMantissaB, guardBit, roundBit, stickyBit, special, specialWord);
    modport sink   (input  valid, signA, signB, exponentOut, alignedMantissaA,
                    alignedMantissaB, guardBit, roundBit, stickyBit, special, specialWord);
endinterface

// Raw signed-magnitude sum, combinational from alignBus
interface sumBus;
    logic                    valid;
    logic                    sign;
    logic [fpPkg::EXP_W-1:0] exponent;
    logic [fpPkg::SUM_W-1:0] sum;                 // Carry, 24 magnitude bits, guard, round, sticky
    logic                    special;
    fpPkg::fpWord            specialWord;

    modport source (output valid, sign, exponent, sum, special, specialWord);
    modport sink   (input  valid, sign, exponent, sum, special, specialWord);
endinterface

// File: src/alignment.sv
// Stage one of the adder, compares exponents, aligns the smaller operand and flags special inputs
`timescale 1ns/100ps

module alignment
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         inValid,
    input  fpPkg::fpWord opA,
    input  fpPkg::fpWord opB,
    alignBus.source      bus
);

    localparam int ALN_W = fpPkg::EXT_W + 2;     // Hidden one, fraction, guard and round slots

    logic                    nanA, nanB;
    logic                    infA, infB;
    logic                    aLarger;
    logic [fpPkg::EXP_W-1:0] expDiff;
    logic [fpPkg::EXP_W-1:0] expOut;
    logic [ALN_W-1:0]        extA, extB;
    logic [ALN_W-1:0]        shiftIn, shifted;
    logic [ALN_W-1:0]        stickyMask;
    logic [fpPkg::EXT_W-1:0] mantA, mantB;
    logic                    guardBit, roundBit, stickyBit;
    logic                    special;
    fpPkg::fpWord            specialWord;

    always_comb
    begin
        nanA = (opA.f.exponent == fpPkg::EXP_MAX) && (opA.f.fraction != '0);
        nanB = (opB.f.exponent == fpPkg::EXP_MAX) && (opB.f.fraction != '0);
        infA = (opA.f.exponent == fpPkg::EXP_MAX) && (opA.f.fraction == '0);
        infB = (opB.f.exponent == fpPkg::EXP_MAX) && (opB.f.fraction == '0);

        // Exponent zero flushes the whole operand, denormal fraction included
        extA = (opA.f.exponent == '0) ? '0 : {1'b1, opA.f.fraction, 2'b00};
        extB = (opB.f.exponent == '0) ? '0 : {1'b1, opB.f.fraction, 2'b00};

        aLarger = (opA.f.exponent >= opB.f.exponent);
        expOut  = aLarger ? opA.f.exponent : opB.f.exponent;
        expDiff = aLarger ? (opA.f.exponent - opB.f.exponent)
                          : (opB.f.exponent - opA.f.exponent);

        // Smaller operand moves right by the exponent difference
        shiftIn = aLarger ? extB : extA;
        shifted = shiftIn >> expDiff;

        if (expDiff > 8'(ALN_W))
            stickyMask = '1;                     // Everything falls past round
        else
            stickyMask = (ALN_W'(1) << expDiff) - ALN_W'(1);

        stickyBit = |(shiftIn & stickyMask);
        guardBit  = shifted[1];
        roundBit  = shifted[0];
        mantA     = aLarger ? extA[ALN_W-1:2] : shifted[ALN_W-1:2];
        mantB     = aLarger ? shifted[ALN_W-1:2] : extB[ALN_W-1:2];

        special          = 1'b0;
        specialWord.bits = '0;
        if (opA.f.exponent == fpPkg::EXP_MAX || opB.f.exponent == fpPkg::EXP_MAX)
        begin
            special = 1'b1;
            // Any NaN or inf minus inf is invalid
            if (nanA || nanB || (infA && infB && (opA.f.sign != opB.f.sign)))
                specialWord.bits = fpPkg::QNAN;
            else if (infA)
                specialWord = opA;
            else
                specialWord = opB;
        end
        else if (opA.f.exponent == '0 && opB.f.exponent == '0)
        begin
            special            = 1'b1;
            specialWord.f.sign = opA.f.sign & opB.f.sign;   // -0 only from two negative zeros
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            bus.valid <= 1'b0;
        else
            bus.valid <= inValid;
    end

    // Payload follows a new operation only
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            bus.signA            <= opA.f.sign;
            bus.signB            <= opB.f.sign;
            bus.exponentOut      <= expOut;
            bus.alignedMantissaA <= mantA;
            bus.alignedMantissaB <= mantB;
            bus.guardBit         <= guardBit;
            bus.roundBit         <= roundBit;
            bus.stickyBit        <= stickyBit;
            bus.special          <= special;
            bus.specialWord      <= specialWord;
        end
    end

    // Operand with the larger exponent always keeps its hidden one
    assert property (@(posedge clk) disable iff (!arstN)
        (bus.valid && !bus.special) |->
            (bus.alignedMantissaA[fpPkg::EXT_W-1] || bus.alignedMantissaB[fpPkg::EXT_W-1]))
        else $error("Aligned mantissas lost the leading one");

endmodule

// File: src/mantissaAdder.sv
// Combinational signed-magnitude add or subtract of the aligned mantissas between the two stages
`timescale 1ns/100ps

module mantissaAdder
(
    alignBus.sink aBus,
    sumBus.source sBus
);

    localparam int OPD_W = fpPkg::EXT_W + 3;     // Mantissa with guard, round and sticky

    logic [2:0]              grs;
    logic                    grsOnB;
    logic [OPD_W-1:0]        opdA, opdB;
    logic                    aGreater;
    logic [OPD_W-1:0]        larger, smaller;
    logic [fpPkg::SUM_W-1:0] rawDiff;

    always_comb
    begin
        grs = {aBus.guardBit, aBus.roundBit, aBus.stickyBit};

        // Extra bits belong to the shifted operand whose top bit is clear
        grsOnB = aBus.alignedMantissaA[fpPkg::EXT_W-1];
        opdA   = {aBus.alignedMantissaA, (grsOnB ? 3'b000 : grs)};
        opdB   = {aBus.alignedMantissaB, (grsOnB ? grs : 3'b000)};

        aGreater = (opdA >= opdB);
        larger   = aGreater ? opdA : opdB;
        smaller  = aGreater ? opdB : opdA;
        rawDiff  = {1'b0, larger} - {1'b0, smaller};

        if (aBus.signA == aBus.signB)
        begin
            sBus.sum  = {1'b0, opdA} + {1'b0, opdB};    // Carry kept in the top bit
            sBus.sign = aBus.signA;
        end
        else
        begin
            sBus.sum = rawDiff;
            // Exact cancellation is +0
            if (rawDiff == '0)
                sBus.sign = 1'b0;
            else
                sBus.sign = aGreater ? aBus.signA : aBus.signB;
        end
    end

    assign sBus.valid       = aBus.valid;
    assign sBus.exponent    = aBus.exponentOut;
    assign sBus.special     = aBus.special;
    assign sBus.specialWord = aBus.specialWord;

endmodule

// File: src/normalizeRound.sv
// Stage two of the adder, normalizes the raw sum, rounds to nearest even and registers the result
`timescale 1ns/100ps

module normalizeRound
(
    input  logic         clk,
    input  logic         arstN,
    sumBus.sink          bus,
    output logic         outValid,
    output fpPkg::fpWord result
);

    localparam int OPD_W = fpPkg::SUM_W - 1;     // Sum below the carry bit
    localparam int POS_W = $clog2(OPD_W);
    localparam int EXP_S = fpPkg::EXP_W + 2;     // Room for overflow and underflow

    localparam logic signed [EXP_S-1:0] EXP_TOP = $signed({2'b00, fpPkg::EXP_MAX});

    logic [POS_W-1:0]        leadPos;
    logic [POS_W-1:0]        shiftAmt;
    logic [OPD_W-1:0]        norm;
    logic [fpPkg::EXT_W-1:0] mant;
    logic                    guardBit, roundBit, stickyBit;
    logic                    roundUp;
    logic [fpPkg::EXT_W:0]   rounded;
    logic [fpPkg::EXT_W-1:0] mantFinal;
    logic signed [EXP_S-1:0] expAdj;
    logic signed [EXP_S-1:0] expFinal;
    fpPkg::fpWord            packedWord;

    always_comb
    begin
        // Highest set bit wins
        leadPos = '0;
        for (int i = 0; i < OPD_W; i++)
        begin
            if (bus.sum[i])
                leadPos = POS_W'(i);
        end
        shiftAmt = POS_W'(OPD_W - 1) - leadPos;
        norm     = bus.sum[OPD_W-1:0] << shiftAmt;

        if (bus.sum[fpPkg::SUM_W-1])
        begin
            // Carry out, one place right with the dropped bit folded into sticky
            mant      = bus.sum[fpPkg::SUM_W-1 -: fpPkg::EXT_W];
            guardBit  = bus.sum[3];
            roundBit  = bus.sum[2];
            stickyBit = bus.sum[1] | bus.sum[0];
            expAdj    = $signed({2'b00, bus.exponent}) + EXP_S'(1);
        end
        else
        begin
            mant      = norm[OPD_W-1 -: fpPkg::EXT_W];
            guardBit  = norm[2];
            roundBit  = norm[1];
            stickyBit = norm[0];
            expAdj    = $signed({2'b00, bus.exponent}) - $signed({{(EXP_S-POS_W){1'b0}}, shiftAmt});
        end

        roundUp = guardBit & (roundBit | stickyBit | mant[0]);    // Nearest, ties to even
        rounded = {1'b0, mant} + {{fpPkg::EXT_W{1'b0}}, roundUp};

        if (rounded[fpPkg::EXT_W])
        begin
            mantFinal = rounded[fpPkg::EXT_W:1];     // All ones rolled over
            expFinal  = expAdj + EXP_S'(1);
        end
        else
        begin
            mantFinal = rounded[fpPkg::EXT_W-1:0];
            expFinal  = expAdj;
        end

        packedWord.bits   = '0;
        packedWord.f.sign = bus.sign;
        if (bus.special)
            packedWord = bus.specialWord;
        else if (bus.sum == '0)
            packedWord.bits = '0;
        else if (expFinal >= EXP_TOP)
            packedWord.f.exponent = fpPkg::EXP_MAX;      // Signed infinity
        else if (expFinal > 0)
        begin
            packedWord.f.exponent = expFinal[fpPkg::EXP_W-1:0];
            packedWord.f.fraction = mantFinal[fpPkg::MAN_W-1:0];
        end
        // Underflow stays as signed zero
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            outValid <= 1'b0;
        else
            outValid <= bus.valid;
    end

    always_ff @(posedge clk)
    begin
        if (bus.valid)
            result <= packedWord;                // Held between operations
    end

    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid))
        else $error("outValid is unknown after reset");

endmodule

// File: src/fpAdder.sv
// Top level of the two-stage single-precision adder, takes one operation on every valid cycle
`timescale 1ns/100ps

module fpAdder
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         inValid,     // One operation per high cycle
    input  fpPkg::fpWord opA,
    input  fpPkg::fpWord opB,
    output logic         outValid,    // Pulses two edges after inValid is sampled
    output fpPkg::fpWord result
);

    alignBus aBus();
    sumBus   sBus();

    alignment u_alignment
    (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .opA     (opA),
        .opB     (opB),
        .bus     (aBus.source)
    );

    mantissaAdder u_mantissaAdder
    (
        .aBus (aBus.sink),
        .sBus (sBus.source)
    );

    normalizeRound u_normalizeRound
    (
        .clk      (clk),
        .arstN    (arstN),
        .bus      (sBus.sink),
        .outValid (outValid),
        .result   (result)
    );

endmodule

// File: verif/fpAdderTb.sv
// Directed testbench for the pipelined float adder that runs as the simulation top over list.f
`timescale 1ns/100ps

module fpAdderTb;

    localparam int TIMEOUT_CYCLES = 3000;        // Roughly twice the longest run of all tests

    logic         clk = 1'b0;
    logic         arstN;
    logic         inValid;
    fpPkg::fpWord opA;
    fpPkg::fpWord opB;
    logic         outValid;
    fpPkg::fpWord result;

    int          cycles = 0;
    int          seed = 94023;
    logic [31:0] expectQ[$];                     // Streamed results in input order
    int          dueQ[$];                        // Cycle at which each streamed result is due

    fpAdder u_fpAdder
    (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .outValid (outValid),
        .result   (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            reportFailure("Timeout, the tests did not finish within the cycle limit");
    end

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            reportFailure("Value mismatch");
        end
    endtask

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // One isolated operation with its exact latency and pulse length
    task automatic addOnce(input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] expected, input string name);
        inValid  = 1'b1;
        opA.bits = a;
        opB.bits = b;
        stepCycle();                             // Sampling edge
        inValid  = 1'b0;
        opA.bits = ~a;                           // Later operands must not reach result
        if (outValid)
            reportFailure("outValid rose one edge after the input, one edge early");
        stepCycle();
        if (!outValid)
            reportFailure("outValid missing two edges after the input was sampled");
        checkEqual({"result of ", name}, expected, result);
        stepCycle();
        if (outValid)
            reportFailure("outValid stayed high for more than one cycle");
        checkEqual({"result held after ", name}, expected, result);
    endtask

    task automatic testResetAndLatency();
        arstN   = 1'b0;
        inValid = 1'b1;                          // Ignored while reset is held
        repeat (8)
        begin
            stepCycle();
            checkEqual("outValid in reset", 32'(0), 32'(outValid));
        end
        arstN   = 1'b1;
        inValid = 1'b0;
        repeat (3)
        begin
            stepCycle();
            checkEqual("outValid idle", 32'(0), 32'(outValid));
        end
        addOnce(32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, "1.0 + 2.0");
    endtask

    task automatic testExactArithmetic();
        addOnce(32'h3FC0_0000, 32'hBF00_0000, 32'h3F80_0000, "1.5 + -0.5");
        addOnce(32'h4040_0000, 32'h4040_0000, 32'h40C0_0000, "3.0 + 3.0");
        addOnce(32'h3F80_0000, 32'hBF40_0000, 32'h3E80_0000, "1.0 + -0.75");
        addOnce(32'h4000_0000, 32'hC000_0000, 32'h0000_0000, "2.0 + -2.0");
    endtask

    task automatic testRounding();
        addOnce(32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000, "tie to even low");
        addOnce(32'h3F80_0000, 32'h33C0_0000, 32'h3F80_0001, "above half");
        addOnce(32'h3F80_0000, 32'h0DA2_4260, 32'h3F80_0000, "sticky only");
        addOnce(32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002, "tie to even high");
    endtask

    task automatic testSpecialValues();
        addOnce(32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000, "NaN + 1.0");
        addOnce(32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000, "inf + -inf");
        addOnce(32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000, "inf + 1.0");
        addOnce(32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000, "overflow");
        addOnce(32'h0000_0001, 32'h3F80_0000, 32'h3F80_0000, "denormal + 1.0");
        addOnce(32'h8000_0000, 32'h8000_0000, 32'h8000_0000, "-0 + -0");
        addOnce(32'h8000_0000, 32'h0000_0000, 32'h0000_0000, "-0 + +0");
    endtask

    // Output must appear exactly on the due cycle and nowhere else
    task automatic checkStreamOutput();
        if (dueQ.size() > 0 && dueQ[0] == cycles)
        begin
            if (!outValid)
                reportFailure("Streamed result missing on its due cycle");
            checkEqual("streamed result", expectQ.pop_front(), result);
            void'(dueQ.pop_front());
        end
        else if (outValid)
            reportFailure("outValid high with no streamed result due");
    endtask

    task automatic sendStream(input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] expected);
        int idle;
        inValid  = 1'b1;
        opA.bits = a;
        opB.bits = b;
        expectQ.push_back(expected);
        dueQ.push_back(cycles + 2);
        stepCycle();
        checkStreamOutput();
        inValid = 1'b0;
        idle    = int'({$random(seed)} % 3);     // Zero keeps inputs back to back
        repeat (idle)
        begin
            stepCycle();
            checkStreamOutput();
        end
    endtask

    task automatic testStreamedIdentities();
        fpPkg::fpWord x;
        fpPkg::fpWord negX;
        for (int n = 0; n < 200; n++)
        begin
            x.f.sign     = 1'($random(seed));
            x.f.exponent = 8'(1 + ({$random(seed)} % 254));    // Normal numbers only
            x.f.fraction = 23'($random(seed));
            negX         = x;
            negX.f.sign  = ~x.f.sign;
            sendStream(x.bits, negX.bits, 32'h0000_0000);
            sendStream(x.bits, 32'h0000_0000, x.bits);
        end
        while (dueQ.size() > 0)
        begin
            stepCycle();
            checkStreamOutput();
        end
    endtask

    initial
    begin
        arstN    = 1'b0;
        inValid  = 1'b0;
        opA.bits = '0;
        opB.bits = '0;
        #1;
        testResetAndLatency();
        testExactArithmetic();
        testRounding();
        testSpecialValues();
        testStreamedIdentities();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: list.f
src/fpPkg.sv
src/fpBusIf.sv
src/alignment.sv
src/mantissaAdder.sv
src/normalizeRound.sv
src/fpAdder.sv
verif/fpAdderTb.sv

// File: Makefile
# Verilator build and run of the float adder testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module fpAdderTb \
		-f list.f -Mdir obj_dir -o fpAdderSim
	./obj_dir/fpAdderSim

clean:
	rm -rf obj_dir
